// File: all.f
+incdir+verilog
verilog/fmul_pkg.sv
verilog/fmul_classify.sv
verilog/fmul_mantissa_mul.sv
verilog/fmul_round.sv
verilog/fmul_top.sv
tests/tb_clock.sv
tests/fmul_checker.sv
tests/tb_fmul.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fmul -f all.f

sim_out=$(./obj_dir/Vtb_fmul)
echo "$sim_out"

if echo "$sim_out" | grep -q "^Testbench passed$"; then
    exit 0
else
    exit 1
fi

// File: tests/fmul_checker.sv
`include "fmul_macros.svh"

module fmul_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_ready,
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    input  logic [2:0]           rm,
    input  logic [`ID_WIDTH-1:0] in_id,
    input  logic                 out_valid,
    input  logic                 out_ready,
    input  logic [31:0]          result,
    input  logic [4:0]           fflags,
    input  logic [`ID_WIDTH-1:0] out_id,
    input  int                   test_idx,
    input  logic                 test_done,
    input  logic                 check_latency,
    output int                   pending,
    output int                   check_count,
    output int                   error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // {id, fflags, result} per item in flight
    logic [`ID_WIDTH+36:0] expect_q [$];
    int                    accept_q [$];
    logic [`ID_WIDTH+36:0] held;
    logic                  stalled;
    logic                  ready_want;
    int                    cycle;
    int                    test_checks;
    int                    test_errors;

    ////////////////////////////////////////////////////////////////////////////
    // reference model returning {fflags, result}

    function automatic logic [36:0] ref_mul(input logic [31:0] x, input logic [31:0] y,
                                            input logic [2:0] rm_in);
        logic        s, zx, zy, ix, iy, nx, ny, inv;
        logic        g, r, st, inexact, half, above, up, to_inf;
        int          e;
        logic [47:0] p;
        logic [24:0] m;
        logic [22:0] frac;
        logic [2:0]  mode;
        logic [4:0]  fl;

        fl = '0;
        s  = x[31] ^ y[31];
        // subnormals have exponent 0 and count as zero
        zx = (x[30:23] == 8'h00);
        zy = (y[30:23] == 8'h00);
        ix = (x[30:23] == 8'hff) && (x[22:0] == '0);
        iy = (y[30:23] == 8'hff) && (y[22:0] == '0);
        nx = (x[30:23] == 8'hff) && (x[22:0] != '0);
        ny = (y[30:23] == 8'hff) && (y[22:0] != '0);
        inv = (zx && iy) || (ix && zy) || (nx && !x[22]) || (ny && !y[22]);

        if (inv || nx || ny) begin
            fl[`FLAG_NV] = inv;
            return {fl, `CANONICAL_NAN};
        end
        if (ix || iy) begin
            return {fl, s, 8'hff, 23'h0};
        end
        if (zx || zy) begin
            return {fl, s, 31'h0};
        end

        p = {24'h0, 1'b1, x[22:0]} * {24'h0, 1'b1, y[22:0]};
        e = int'(x[30:23]) + int'(y[30:23]) - `EXPO_BIAS;
        // product lies in [1,4) and its leading one goes to bit 47
        if (p[47]) begin
            e = e + 1;
        end else begin
            p = p << 1;
        end
        m       = {1'b0, p[47:24]};
        g       = p[23];
        r       = p[22];
        st      = |p[21:0];
        inexact = g || r || st;
        half    = g && !(r || st);
        above   = g && (r || st);

        mode = (rm_in > `RM_RMM) ? `RM_RNE : rm_in;
        case (mode)
            `RM_RNE: up = above || (half && m[0]);
            `RM_RTZ: up = 1'b0;
            `RM_RDN: up = s && inexact;
            `RM_RUP: up = !s && inexact;
            default: up = g;
        endcase
        to_inf = (mode == `RM_RNE) || (mode == `RM_RMM) ||
                 (mode == `RM_RDN && s) || (mode == `RM_RUP && !s);

        m = m + 25'(up);
        if (m[24]) begin
            e = e + 1;
        end
        frac = m[24] ? 23'h0 : m[22:0];

        if (e >= `EXPO_MAX) begin
            fl[`FLAG_OF] = 1'b1;
            fl[`FLAG_NX] = 1'b1;
            return to_inf ? {fl, s, 8'hff, 23'h0} : {fl, s, 8'hfe, 23'h7fffff};
        end
        if (e <= 0) begin
            fl[`FLAG_UF] = 1'b1;
            fl[`FLAG_NX] = 1'b1;
            return {fl, s, 31'h0};
        end
        fl[`FLAG_NX] = inexact;
        return {fl, s, 8'(e), frac};
    endfunction

    function automatic string test_label(input int idx);
        case (idx)
            1:       return "exact products";
            2:       return "special cases";
            3:       return "rounding modes";
            4:       return "range limits";
            5:       return "back-pressure";
            6:       return "latency";
            default: return "reset";
        endcase
    endfunction

    task automatic count_error();
        error_count = error_count + 1;
        test_errors = test_errors + 1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // inputs and outputs are sampled as they were before each edge

    always @(posedge clk) begin : compare
        logic [`ID_WIDTH+36:0] want;
        logic [`ID_WIDTH+36:0] got;
        int                    t0;

        cycle = cycle + 1;
        got   = {out_id, fflags, result};
        if (rst_n) begin
            if (stalled && (!out_valid || got != held)) begin
                $display("FAIL %s: output not held under stall, expected %h actual %h",
                         test_label(test_idx), held, got);
                count_error();
            end
            // three stages, so only a full pipeline with a stalled output refuses
            ready_want = (expect_q.size() < 3) || out_ready;
            if (in_ready !== ready_want) begin
                $display("FAIL %s: in_ready expected %b actual %b",
                         test_label(test_idx), ready_want, in_ready);
                count_error();
            end
            if (in_valid && in_ready) begin
                expect_q.push_back({in_id, ref_mul(a, b, rm)});
                accept_q.push_back(cycle);
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("ERROR %s: the DUT returned a result with nothing in flight",
                             test_label(test_idx));
                    count_error();
                end else begin
                    want        = expect_q.pop_front();
                    t0          = accept_q.pop_front();
                    check_count = check_count + 1;
                    test_checks = test_checks + 1;
                    if (got != want) begin
                        $display("FAIL %s: expected id %0d %h flags %b actual id %0d %h flags %b",
                                 test_label(test_idx), want[40:37], want[31:0], want[36:32],
                                 out_id, result, fflags);
                        count_error();
                    end
                    if (check_latency && (cycle - t0 != 3)) begin
                        $display("FAIL %s: latency expected 3 actual %0d",
                                 test_label(test_idx), cycle - t0);
                        count_error();
                    end
                end
            end
            if (test_done) begin
                $display("%s: %0d results checked, %0d errors",
                         test_label(test_idx), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
        stalled = rst_n && out_valid && !out_ready;
        held    = got;
        pending = expect_q.size();
    end

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low over three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tests/tb_fmul.sv
`include "fmul_macros.svh"

module tb_fmul;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STEP_LIMIT  = 100;
    localparam int DRAIN_LIMIT = 500;

    logic                 clk, rst_n;
    logic                 in_valid, in_ready, out_valid, out_ready;
    logic [31:0]          a, b, result;
    logic [2:0]           rm;
    logic [`ID_WIDTH-1:0] in_id, out_id, next_id;
    logic [4:0]           fflags;
    logic                 test_done, check_latency, ready_random, hung;
    int                   test_idx, pending, check_count, error_count;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    fmul_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .rm        (rm),
        .in_id     (in_id),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .fflags    (fflags),
        .out_id    (out_id)
    );

    fmul_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .a             (a),
        .b             (b),
        .rm            (rm),
        .in_id         (in_id),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .result        (result),
        .fflags        (fflags),
        .out_id        (out_id),
        .test_idx      (test_idx),
        .test_done     (test_done),
        .check_latency (check_latency),
        .pending       (pending),
        .check_count   (check_count),
        .error_count   (error_count)
    );

    // random back-pressure on the output side when enabled
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = ready_random ? ($urandom_range(0, 3) != 0) : 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    function automatic logic [31:0] rand_normal();
        logic [7:0] e;

        // exponents near the middle keep most products in range
        e = 8'(64 + $urandom_range(0, 126));
        return {1'($urandom_range(0, 1)), e, 23'($urandom)};
    endfunction

    task automatic wait_reset();
        int waited;

        waited = 0;
        while (rst_n !== 1'b1 && !hung) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > STEP_LIMIT) begin
                $display("timeout: reset was never released");
                hung = 1'b1;
            end
        end
    endtask

    // present one item and return once in_ready shows it is taken on the next edge
    task automatic send_op(input logic [31:0] x, input logic [31:0] y,
                           input logic [2:0] mode);
        int waited;

        waited = 0;
        if (hung) return;
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        rm       = mode;
        in_id    = next_id;
        next_id  = next_id + 1'b1;
        #1;
        while (!in_ready && !hung) begin
            @(negedge clk);
            #1;
            waited = waited + 1;
            if (waited > STEP_LIMIT) begin
                $display("timeout: in_ready stayed low for %0d cycles", STEP_LIMIT);
                hung = 1'b1;
            end
        end
    endtask

    task automatic drain_pipe();
        int waited;

        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        #1;
        while (pending != 0 && !hung) begin
            @(negedge clk);
            #1;
            waited = waited + 1;
            if (waited > DRAIN_LIMIT) begin
                $display("timeout: %0d results never came out", pending);
                hung = 1'b1;
            end
        end
    endtask

    task automatic end_test();
        drain_pipe();
        @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    task automatic range_pair(input logic [31:0] x, input logic [31:0] y);
        // codes 5 to 7 must act as RNE
        for (int m = 0; m < 8; m++) begin
            send_op(x, y, 3'(m));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic exact_products();
        test_idx = 1;
        send_op(32'h40000000, 32'h40400000, `RM_RNE);
        send_op(32'h3fc00000, 32'h3fc00000, `RM_RNE);
        send_op(32'h41200000, 32'h41200000, `RM_RNE);
        send_op(32'h3e800000, 32'h43000000, `RM_RNE);
        send_op(32'hc0a00000, 32'h40e00000, `RM_RNE);
        send_op(32'h3f800000, 32'h3f800000, `RM_RNE);
        send_op(32'h41400000, 32'hc1a80000, `RM_RNE);
        end_test();
    endtask

    task automatic special_cases();
        test_idx = 2;
        send_op(32'h7fc00000, 32'h3f800000, `RM_RNE);
        send_op(32'h7f800001, 32'h3f800000, `RM_RNE);
        send_op(32'h40000000, 32'hffa00000, `RM_RTZ);
        send_op(32'h7f800000, 32'h00000000, `RM_RNE);
        send_op(32'h80000000, 32'hff800000, `RM_RUP);
        send_op(32'h7f800000, 32'hc0000000, `RM_RNE);
        send_op(32'hff800000, 32'hff800000, `RM_RDN);
        send_op(32'h80000000, 32'h40400000, `RM_RNE);
        send_op(32'h00000001, 32'h40000000, `RM_RNE);
        send_op(32'h7f800001, 32'h7f800000, `RM_RMM);
        send_op(32'h7fc00000, 32'h00000000, `RM_RNE);
        end_test();
    endtask

    task automatic rounding_modes();
        test_idx = 3;
        for (int m = 0; m < 5; m++) begin
            for (int i = 0; i < 200; i++) begin
                send_op(rand_normal(), rand_normal(), 3'(m));
            end
        end
        end_test();
    endtask

    task automatic range_limits();
        test_idx = 4;
        range_pair(32'h7f000000, 32'h40000000);
        range_pair(32'h7f7fffff, 32'h7f7fffff);
        range_pair(32'hff7fffff, 32'h3f800001);
        range_pair(32'h7f7fffff, 32'h3f800000);
        range_pair(32'h00800000, 32'h00800000);
        range_pair(32'h00800000, 32'h3f000000);
        range_pair(32'h00800000, 32'h3f800000);
        range_pair(32'h80ffffff, 32'h3f7fffff);
        end_test();
    endtask

    task automatic back_pressure();
        test_idx     = 5;
        ready_random = 1'b1;
        for (int i = 0; i < 80; i++) begin
            send_op(rand_normal(), rand_normal(), 3'($urandom_range(0, 7)));
        end
        end_test();
        ready_random = 1'b0;
    endtask

    task automatic latency_test();
        test_idx      = 6;
        check_latency = 1'b1;
        // each item alone in the pipeline
        for (int i = 0; i < 4; i++) begin
            send_op(rand_normal(), rand_normal(), `RM_RNE);
            drain_pipe();
        end
        end_test();
        check_latency = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(32'he00b));
        in_valid      = 1'b0;
        a             = '0;
        b             = '0;
        rm            = `RM_RNE;
        in_id         = '0;
        next_id       = '0;
        test_done     = 1'b0;
        check_latency = 1'b0;
        ready_random  = 1'b0;
        hung          = 1'b0;
        test_idx      = 0;

        wait_reset();
        exact_products();
        special_cases();
        rounding_modes();
        range_limits();
        back_pressure();
        latency_test();

        @(negedge clk);
        $display("%0d results checked, %0d errors", check_count, error_count);
        if (!hung && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog/fmul_classify.sv
`include "fmul_macros.svh"

module fmul_classify import fmul_pkg::*; (
    input  fp32_t                        a,
    input  fp32_t                        b,
    output logic                         sign,
    output logic signed [`EXPO_WIDTH+1:0] expo_sum,
    output logic [`FRAC_WIDTH:0]         sig_a,
    output logic [`FRAC_WIDTH:0]         sig_b,
    output logic                         is_nan_out,
    output logic                         is_inf_out,
    output logic                         is_zero_out,
    output logic                         invalid
);

    logic a_zero, a_max, a_inf, a_nan, a_snan;
    logic b_zero, b_max, b_inf, b_nan, b_snan;

    ////////////////////////////////////////////////////////////////////////////
    // operand decode

    // subnormals have expo 0 and are flushed to zero
    assign a_zero = (a.fields.expo == '0);
    assign b_zero = (b.fields.expo == '0);

    assign a_max  = (a.fields.expo == `EXPO_WIDTH'(`EXPO_MAX));
    assign b_max  = (b.fields.expo == `EXPO_WIDTH'(`EXPO_MAX));

    assign a_inf  = a_max & (a.fields.frac == '0);
    assign b_inf  = b_max & (b.fields.frac == '0);
    assign a_nan  = a_max & (a.fields.frac != '0);
    assign b_nan  = b_max & (b.fields.frac != '0);

    // quiet bit is the fraction msb
    assign a_snan = a_nan & ~a.fields.frac[`FRAC_WIDTH-1];
    assign b_snan = b_nan & ~b.fields.frac[`FRAC_WIDTH-1];

    ////////////////////////////////////////////////////////////////////////////
    // exception decisions

    assign invalid     = (a_zero & b_inf) | (a_inf & b_zero) | a_snan | b_snan;
    assign is_nan_out  = invalid | a_nan | b_nan;
    assign is_inf_out  = (a_inf | b_inf) & ~is_nan_out;
    assign is_zero_out = (a_zero | b_zero) & ~is_nan_out;

    ////////////////////////////////////////////////////////////////////////////
    // sign, exponent and significands

    assign sign = a.fields.sign ^ b.fields.sign;

    // two extra bits keep overflow and negative sums visible
    assign expo_sum = $signed({2'b00, a.fields.expo})
                    + $signed({2'b00, b.fields.expo})
                    - $signed((`EXPO_WIDTH+2)'(`EXPO_BIAS));

    // hidden bit only for normal operands
    assign sig_a = {~a_zero, a.fields.frac};
    assign sig_b = {~b_zero, b.fields.frac};

endmodule

// File: verilog/fmul_macros.svh
`ifndef FMUL_MACROS_SVH
`define FMUL_MACROS_SVH

// fp32 word layout
`define FP_WIDTH      32
`define EXPO_WIDTH    8
`define FRAC_WIDTH    23
`define EXPO_BIAS     127
`define EXPO_MAX      255
`define CANONICAL_NAN 32'h7fc00000

// transaction tag
`define ID_WIDTH      4

// rounding modes, anything above RMM behaves as RNE
`define RM_RNE        3'd0
`define RM_RTZ        3'd1
`define RM_RDN        3'd2
`define RM_RUP        3'd3
`define RM_RMM        3'd4

// bit positions in fflags, DZ (bit 3) never set by a multiply
`define FLAG_NV       4
`define FLAG_OF       2
`define FLAG_UF       1
`define FLAG_NX       0

`endif

// File: verilog/fmul_mantissa_mul.sv
`include "fmul_macros.svh"

module fmul_mantissa_mul (
    input  logic                      clk,
    input  logic                      advance1,
    input  logic                      advance2,
    input  logic [`FRAC_WIDTH:0]      sig_a,
    input  logic [`FRAC_WIDTH:0]      sig_b,
    output logic [2*`FRAC_WIDTH+1:0]  product
);

    // significand width including the hidden bit
    localparam int SIG_W = `FRAC_WIDTH + 1;

    logic [SIG_W-1:0] op_a;
    logic [SIG_W-1:0] op_b;

    ////////////////////////////////////////////////////////////////////////////
    // first register, stage 1 operands

    always_ff @(posedge clk) begin
        if (advance1) begin
            op_a <= sig_a;
            op_b <= sig_b;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // second register, full width product

    // both registers hold under a stall, so the multiply
    // result stays aligned with the sideband in the top
    always_ff @(posedge clk) begin
        if (advance2) begin
            product <= op_a * op_b;
        end
    end

endmodule

// File: verilog/fmul_pkg.sv
`include "fmul_macros.svh"

package fmul_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // fp32 word types

    // ieee 754 single precision fields, msb first
    typedef struct packed {
        logic                   sign;
        logic [`EXPO_WIDTH-1:0] expo;
        logic [`FRAC_WIDTH-1:0] frac;
    } fp32_fields_t;

    // same 32 bits read either as a raw word or as fields
    typedef union packed {
        logic [`FP_WIDTH-1:0] word;
        fp32_fields_t         fields;
    } fp32_t;

endpackage

// File: verilog/fmul_round.sv
`include "fmul_macros.svh"

module fmul_round import fmul_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          advance,
    input  logic                          valid_in,
    input  logic [2*`FRAC_WIDTH+1:0]      product,
    input  logic                          sign,
    input  logic signed [`EXPO_WIDTH+1:0] expo_sum,
    input  logic [2:0]                    rm,
    input  logic [`ID_WIDTH-1:0]          id_in,
    input  logic                          is_nan_out,
    input  logic                          is_inf_out,
    input  logic                          is_zero_out,
    input  logic                          invalid,
    output logic                          valid_out,
    output fp32_t                         result,
    output logic [4:0]                    fflags,
    output logic [`ID_WIDTH-1:0]          id_out
);

    localparam int SIG_W = `FRAC_WIDTH + 1;
    localparam int P_MSB = 2 * `FRAC_WIDTH + 1;

    logic                          shift;
    logic [SIG_W-1:0]              sig_norm;
    logic                          guard, round_bit, sticky, inexact;
    logic signed [`EXPO_WIDTH+1:0] expo_norm, expo_round;
    logic [2:0]                    mode;
    logic                          round_up, ovf_to_inf, overflow, underflow;
    logic [SIG_W:0]                sig_round;
    fp32_t                         res_next;
    logic [4:0]                    flags_next;

    ////////////////////////////////////////////////////////////////////////////
    // one-bit normalize and grs extraction

    assign shift     = product[P_MSB];
    assign sig_norm  = shift ? product[P_MSB -: SIG_W] : product[P_MSB-1 -: SIG_W];
    assign guard     = shift ? product[P_MSB-SIG_W] : product[P_MSB-SIG_W-1];
    assign round_bit = shift ? product[P_MSB-SIG_W-1] : product[P_MSB-SIG_W-2];
    assign sticky    = shift ? |product[P_MSB-SIG_W-2:0] : |product[P_MSB-SIG_W-3:0];
    assign inexact   = guard | round_bit | sticky;
    assign expo_norm = expo_sum + (`EXPO_WIDTH+2)'(shift);

    ////////////////////////////////////////////////////////////////////////////
    // rounding

    // reserved mode codes fall back to nearest-even
    assign mode = (rm > `RM_RMM) ? `RM_RNE : rm;

    always_comb begin
        round_up   = 1'b0;
        ovf_to_inf = 1'b1;
        case (mode)
            `RM_RNE: round_up = guard & (round_bit | sticky | sig_norm[0]);
            `RM_RTZ: ovf_to_inf = 1'b0;
            `RM_RDN: begin
                round_up   = sign & inexact;
                ovf_to_inf = sign;
            end
            `RM_RUP: begin
                round_up   = ~sign & inexact;
                ovf_to_inf = ~sign;
            end
            `RM_RMM: round_up = guard;
            default: round_up = 1'b0;
        endcase
    end

    // carry out leaves an all-zero fraction, only the exponent moves
    assign sig_round  = {1'b0, sig_norm} + (SIG_W+1)'(round_up);
    assign expo_round = expo_norm + (`EXPO_WIDTH+2)'(sig_round[SIG_W]);
    assign overflow   = (expo_round >= `EXPO_MAX);
    assign underflow  = (expo_round <= 0);

    ////////////////////////////////////////////////////////////////////////////
    // result select

    always_comb begin
        res_next.word = '0;
        flags_next    = '0;
        if (is_nan_out) begin
            res_next.word        = `CANONICAL_NAN;
            flags_next[`FLAG_NV] = invalid;
        end else if (is_inf_out) begin
            res_next.fields.sign = sign;
            res_next.fields.expo = '1;
        end else if (is_zero_out) begin
            res_next.fields.sign = sign;
        end else if (overflow) begin
            res_next.fields.sign = sign;
            if (ovf_to_inf) begin
                res_next.fields.expo = '1;
            end else begin
                // largest finite magnitude
                res_next.fields.expo = `EXPO_WIDTH'(`EXPO_MAX - 1);
                res_next.fields.frac = '1;
            end
            flags_next[`FLAG_OF] = 1'b1;
            flags_next[`FLAG_NX] = 1'b1;
        end else if (underflow) begin
            // flush to signed zero
            res_next.fields.sign = sign;
            flags_next[`FLAG_UF] = 1'b1;
            flags_next[`FLAG_NX] = 1'b1;
        end else begin
            res_next.fields.sign = sign;
            res_next.fields.expo = expo_round[`EXPO_WIDTH-1:0];
            res_next.fields.frac = sig_round[`FRAC_WIDTH-1:0];
            flags_next[`FLAG_NX] = inexact;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register, stage 3

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (advance) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result <= res_next;
            fflags <= flags_next;
            id_out <= id_in;
        end
    end

    // a stalled output must be presented unchanged on the next cycle
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !advance |=> $stable(result) && $stable(fflags) && $stable(id_out));

endmodule

// File: verilog/fmul_top.sv
`include "fmul_macros.svh"

module fmul_top import fmul_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fp32_t                a,
    input  fp32_t                b,
    input  logic [2:0]           rm,
    input  logic [`ID_WIDTH-1:0] in_id,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fp32_t                result,
    output logic [4:0]           fflags,
    output logic [`ID_WIDTH-1:0] out_id
);

    logic advance1, advance2, advance3;
    logic s1_valid, s2_valid;

    // classify outputs, same cycle as acceptance
    logic                          c_sign, c_nan, c_inf, c_zero, c_invalid;
    logic signed [`EXPO_WIDTH+1:0] c_expo_sum;
    logic [`FRAC_WIDTH:0]          sig_a, sig_b;
    logic [2*`FRAC_WIDTH+1:0]      product;

    // sideband, index is the stage number
    logic [`ID_WIDTH-1:0]          id_q       [2:1];
    logic [2:0]                    rm_q       [2:1];
    logic                          sign_q     [2:1];
    logic signed [`EXPO_WIDTH+1:0] expo_q     [2:1];
    logic                          nan_q      [2:1];
    logic                          inf_q      [2:1];
    logic                          zero_q     [2:1];
    logic                          invalid_q  [2:1];

    ////////////////////////////////////////////////////////////////////////////
    // stall chain, works back from the output

    assign advance3 = ~out_valid | out_ready;
    assign advance2 = ~s2_valid | advance3;
    assign advance1 = ~s1_valid | advance2;
    assign in_ready = advance1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (advance1) begin
                s1_valid <= in_valid;
            end
            if (advance2) begin
                s2_valid <= s1_valid;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 and 2 sideband

    always_ff @(posedge clk) begin
        if (advance1) begin
            id_q[1]      <= in_id;
            rm_q[1]      <= rm;
            sign_q[1]    <= c_sign;
            expo_q[1]    <= c_expo_sum;
            nan_q[1]     <= c_nan;
            inf_q[1]     <= c_inf;
            zero_q[1]    <= c_zero;
            invalid_q[1] <= c_invalid;
        end
        // moves alongside the product register
        if (advance2) begin
            id_q[2]      <= id_q[1];
            rm_q[2]      <= rm_q[1];
            sign_q[2]    <= sign_q[1];
            expo_q[2]    <= expo_q[1];
            nan_q[2]     <= nan_q[1];
            inf_q[2]     <= inf_q[1];
            zero_q[2]    <= zero_q[1];
            invalid_q[2] <= invalid_q[1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath

    fmul_classify u_classify (
        .a           (a),
        .b           (b),
        .sign        (c_sign),
        .expo_sum    (c_expo_sum),
        .sig_a       (sig_a),
        .sig_b       (sig_b),
        .is_nan_out  (c_nan),
        .is_inf_out  (c_inf),
        .is_zero_out (c_zero),
        .invalid     (c_invalid)
    );

    fmul_mantissa_mul u_mantissa_mul (
        .clk      (clk),
        .advance1 (advance1),
        .advance2 (advance2),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .product  (product)
    );

    fmul_round u_round (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance3),
        .valid_in    (s2_valid),
        .product     (product),
        .sign        (sign_q[2]),
        .expo_sum    (expo_q[2]),
        .rm          (rm_q[2]),
        .id_in       (id_q[2]),
        .is_nan_out  (nan_q[2]),
        .is_inf_out  (inf_q[2]),
        .is_zero_out (zero_q[2]),
        .invalid     (invalid_q[2]),
        .valid_out   (out_valid),
        .result      (result),
        .fflags      (fflags),
        .id_out      (out_id)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checks

    // any edge with reset held leaves the output stage empty
    a_reset_empty: assert property (@(posedge clk) !rst_n |=> !out_valid);

    // an empty first stage never refuses an item
    a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !s1_valid |-> in_ready);

endmodule
